// File: compile.f
+incdir+include
logic/lmem_pkg.sv
logic/lmem_axi_if.sv
logic/lmem_as_axi_ctrl.sv
logic/lmem_burst_map.sv
logic/lmem_user_ext.sv
logic/lmem_reg_pipe.sv
logic/lmem_bank.sv
logic/lmem_as_axi_top.sv
verification/lmem_as_axi_checker.sv
verification/lmem_as_axi_tb.sv

// File: include/lmem_params.svh
// Local memory AXI export parameters shared by the design and testbench

`ifndef LMEM_PARAMS_SVH
`define LMEM_PARAMS_SVH

// Word address width, so the local memory holds 256 words
`define LMEM_ADDR_WIDTH 8

// Data word width
`define LMEM_DATA_WIDTH 32

// AFU user field width, without the internal fragment flag
`define LMEM_AFU_USER_WIDTH 8

// Burst length field holds beats minus one, giving 1 to 16 beats
`define LMEM_LEN_WIDTH 4

// Largest burst accepted by the memory side
`define LMEM_FIU_MAX_BEATS 4

// Width of a fragment beat count, large enough to hold LMEM_FIU_MAX_BEATS
`define LMEM_FRAG_CNT_WIDTH 3

// Read beats allowed in flight past the control gate
`define LMEM_MAX_ACTIVE_RD 8

// User table tag width, giving 4 entries
`define LMEM_TAG_WIDTH 2

// Minimum register depth in front of the memory
`define LMEM_SUGGESTED_REG_STAGES 2

`endif

// File: logic/lmem_as_axi_ctrl.sv
// Local memory control with the registered reset and read beat credit gate

`timescale 1ns/1ps
`default_nettype none

`include "lmem_params.svh"

module lmem_as_axi_ctrl
(
    input  logic axi_afu_if,
    input  logic reset,
    output logic reset_q,

    // Read fragment issued by the burst mapper and its beat count
    input  logic frag_issue,
    input  logic [`LMEM_FRAG_CNT_WIDTH-1:0] frag_beats,

    // One read beat handed back to the AFU
    input  logic rd_beat_done,

    // High while a full-sized fragment still fits under the credit limit
    output logic rd_admit
);

    // Headroom so a full fragment on top of the limit still fits in the counter
    localparam int ACTIVE_W = $clog2(`LMEM_MAX_ACTIVE_RD + `LMEM_FIU_MAX_BEATS + 1);

    logic [ACTIVE_W-1:0] rd_active_cnt;
    logic [ACTIVE_W-1:0] rd_active_nxt;

    // Every stage sees the reset one cycle late, from a single flop
    always_ff @(posedge axi_afu_if)
    begin
        reset_q <= reset;
    end

    // Issue and return may land in the same cycle
    always_comb
    begin
        rd_active_nxt = rd_active_cnt;
        if (frag_issue)
            rd_active_nxt = rd_active_nxt + ACTIVE_W'(frag_beats);
        if (rd_beat_done)
            rd_active_nxt = rd_active_nxt - 1'b1;
    end

    always_ff @(posedge axi_afu_if)
    begin
        if (reset_q)
            rd_active_cnt <= '0;
        else
            rd_active_cnt <= rd_active_nxt;
    end

    // Worst case is assumed for the next fragment, since its size is not known yet
    assign rd_admit = (int'(rd_active_cnt) + `LMEM_FIU_MAX_BEATS <= `LMEM_MAX_ACTIVE_RD);

endmodule

`default_nettype wire

// File: logic/lmem_as_axi_top.sv
// Local memory exported to the AFU as an AXI-style memory with plain ports

`timescale 1ns/1ps
`default_nettype none

`include "lmem_params.svh"

module lmem_as_axi_top
(
    input  logic axi_afu_if,
    input  logic reset,

    // AFU request channel
    input  logic req_valid,
    output logic req_ready,
    input  lmem_pkg::lmem_op_e req_op,
    input  logic [`LMEM_ADDR_WIDTH-1:0] req_addr,
    input  logic [`LMEM_LEN_WIDTH-1:0] req_len,
    input  logic [`LMEM_DATA_WIDTH-1:0] req_wdata,
    input  logic [`LMEM_AFU_USER_WIDTH-1:0] req_user,

    // AFU response channel
    output logic rsp_valid,
    input  logic rsp_ready,
    output lmem_pkg::lmem_op_e rsp_op,
    output logic [`LMEM_DATA_WIDTH-1:0] rsp_rdata,
    output logic rsp_last,
    output logic [`LMEM_AFU_USER_WIDTH-1:0] rsp_user
);

    logic reset_q;
    logic rd_admit;
    logic frag_issue;
    logic [`LMEM_FRAG_CNT_WIDTH-1:0] frag_beats;
    logic rd_beat_done;

    lmem_pkg::lmem_req_t afu_req;
    lmem_pkg::lmem_rsp_t afu_rsp;

    // Links burst mapper, user extension, register pipe and memory
    lmem_axi_if burst_if();
    lmem_axi_if user_if();
    lmem_axi_if mem_if();

    // The fragment flag and tag are filled in further down the chain
    assign afu_req.op = req_op;
    assign afu_req.addr = req_addr;
    assign afu_req.len = req_len;
    assign afu_req.wdata = req_wdata;
    assign afu_req.user = {1'b0, req_user};
    assign afu_req.tag = '0;

    assign rsp_op = afu_rsp.op;
    assign rsp_rdata = afu_rsp.rdata;
    assign rsp_last = afu_rsp.last;
    assign rsp_user = afu_rsp.user[`LMEM_AFU_USER_WIDTH-1:0];

    lmem_as_axi_ctrl ctrl
    (
        .axi_afu_if(axi_afu_if),
        .reset(reset),
        .reset_q(reset_q),
        .frag_issue(frag_issue),
        .frag_beats(frag_beats),
        .rd_beat_done(rd_beat_done),
        .rd_admit(rd_admit)
    );

    // AFU bursts may be longer than the memory accepts
    lmem_burst_map map_bursts
    (
        .axi_afu_if(axi_afu_if),
        .reset_q(reset_q),
        .afu_req_valid(req_valid),
        .afu_req_ready(req_ready),
        .afu_req(afu_req),
        .afu_rsp_valid(rsp_valid),
        .afu_rsp_ready(rsp_ready),
        .afu_rsp(afu_rsp),
        .mem(burst_if),
        .rd_admit(rd_admit),
        .frag_issue(frag_issue),
        .frag_beats(frag_beats),
        .rd_beat_done(rd_beat_done)
    );

    // User bits are kept here since the memory has none
    lmem_user_ext map_user
    (
        .axi_afu_if(axi_afu_if),
        .reset_q(reset_q),
        .up(burst_if),
        .down(user_if)
    );

    // Register stages in front of the memory for timing
    lmem_reg_pipe #(.n_stages(`LMEM_SUGGESTED_REG_STAGES)) mem_pipe
    (
        .axi_afu_if(axi_afu_if),
        .reset_q(reset_q),
        .up(user_if),
        .down(mem_if)
    );

    lmem_bank bank
    (
        .axi_afu_if(axi_afu_if),
        .reset_q(reset_q),
        .port(mem_if)
    );

endmodule

`default_nettype wire

// File: logic/lmem_axi_if.sv
// Valid/ready request and response channel pair between memory pipeline stages

`timescale 1ns/1ps
`default_nettype none

`include "lmem_params.svh"

interface lmem_axi_if;

    // Request channel, flowing toward the memory
    logic req_valid;
    logic req_ready;
    lmem_pkg::lmem_req_t req;

    // Response channel, flowing back toward the AFU
    logic rsp_valid;
    logic rsp_ready;
    lmem_pkg::lmem_rsp_t rsp;

    // Side that issues requests and consumes responses
    modport source
    (
        output req_valid,
        output req,
        input  req_ready,
        input  rsp_valid,
        input  rsp,
        output rsp_ready
    );

    // Side that accepts requests and produces responses
    modport sink
    (
        input  req_valid,
        input  req,
        output req_ready,
        output rsp_valid,
        output rsp,
        input  rsp_ready
    );

endinterface

`default_nettype wire

// File: logic/lmem_bank.sv
// Single-port local memory array serving one request at a time in order

`timescale 1ns/1ps
`default_nettype none

`include "lmem_params.svh"

module lmem_bank
(
    input  logic axi_afu_if,
    input  logic reset_q,
    lmem_axi_if.sink port
);

    localparam int ADDR_W = `LMEM_ADDR_WIDTH;
    localparam int MEM_WORDS = 1 << `LMEM_ADDR_WIDTH;

    logic [`LMEM_DATA_WIDTH-1:0] mem_array [MEM_WORDS];

    // Response register and the read stream position
    logic rsp_valid_q;
    lmem_pkg::lmem_rsp_t rsp_q;
    logic [ADDR_W-1:0] rd_addr;
    logic [`LMEM_LEN_WIDTH-1:0] beats_left;

    logic req_fire;
    logic rsp_fire;

    // Busy for as long as a response is pending
    assign port.req_ready = !reset_q && !rsp_valid_q;
    assign port.rsp_valid = rsp_valid_q;
    assign port.rsp = rsp_q;

    assign req_fire = port.req_valid && port.req_ready;
    assign rsp_fire = rsp_valid_q && port.rsp_ready;

    always_ff @(posedge axi_afu_if)
    begin
        if (reset_q)
            rsp_valid_q <= 1'b0;
        else if (req_fire)
            rsp_valid_q <= 1'b1;
        else if (rsp_fire && rsp_q.last)
            rsp_valid_q <= 1'b0;
    end

    always_ff @(posedge axi_afu_if)
    begin
        if (req_fire)
        begin
            rsp_q.op <= port.req.op;
            rsp_q.user <= port.req.user;
            rsp_q.tag <= port.req.tag;
            if (port.req.op == lmem_pkg::lmem_op_write)
            begin
                // A write is acknowledged with a single final beat
                mem_array[port.req.addr] <= port.req.wdata;
                rsp_q.rdata <= '0;
                rsp_q.last <= 1'b1;
            end
            else
            begin
                rsp_q.rdata <= mem_array[port.req.addr];
                rsp_q.last <= (port.req.len == '0);
                rd_addr <= port.req.addr + 1'b1;
                beats_left <= port.req.len;
            end
        end
        else if (rsp_fire && !rsp_q.last)
        begin
            // Next beat of the stream, the address wraps at the array end
            rsp_q.rdata <= mem_array[rd_addr];
            rsp_q.last <= (beats_left == 1);
            rd_addr <= rd_addr + 1'b1;
            beats_left <= beats_left - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/lmem_burst_map.sv
// Burst mapper that splits AFU read bursts into memory-sized fragments

`timescale 1ns/1ps
`default_nettype none

`include "lmem_params.svh"

module lmem_burst_map
(
    input  logic axi_afu_if,
    input  logic reset_q,

    // AFU side
    input  logic afu_req_valid,
    output logic afu_req_ready,
    input  lmem_pkg::lmem_req_t afu_req,
    output logic afu_rsp_valid,
    input  logic afu_rsp_ready,
    output lmem_pkg::lmem_rsp_t afu_rsp,

    // Memory side, limited to LMEM_FIU_MAX_BEATS per burst
    lmem_axi_if.source mem,

    // Credit handshake with the controller
    input  logic rd_admit,
    output logic frag_issue,
    output logic [`LMEM_FRAG_CNT_WIDTH-1:0] frag_beats,
    output logic rd_beat_done
);

    localparam int LEN_W = `LMEM_LEN_WIDTH;
    localparam int REM_W = `LMEM_LEN_WIDTH + 1;
    localparam int ADDR_W = `LMEM_ADDR_WIDTH;
    localparam int USER_W = `LMEM_AFU_USER_WIDTH;
    localparam int MAX_BEATS = `LMEM_FIU_MAX_BEATS;

    // Command being split, held until its final fragment is accepted
    logic busy;
    lmem_pkg::lmem_op_e cmd_op;
    logic [ADDR_W-1:0] cmd_addr;
    logic [REM_W-1:0] cmd_rem;
    logic [`LMEM_DATA_WIDTH-1:0] cmd_wdata;
    logic [USER_W-1:0] cmd_user;

    logic [REM_W-1:0] frag_cnt;
    logic frag_final;
    logic afu_fire;
    logic frag_fire;
    lmem_pkg::lmem_req_t frag_req;

    // One command at a time, and none while read credits are exhausted
    assign afu_req_ready = !reset_q && !busy && rd_admit;
    assign afu_fire = afu_req_valid && afu_req_ready;

    // Size of the fragment at the head of the current command
    assign frag_final = (cmd_rem <= REM_W'(MAX_BEATS));
    assign frag_cnt = frag_final ? cmd_rem : REM_W'(MAX_BEATS);

    // Writes do not consume read credits
    assign mem.req_valid = busy && ((cmd_op == lmem_pkg::lmem_op_write) || rd_admit);
    assign frag_fire = mem.req_valid && mem.req_ready;

    always_comb
    begin
        frag_req.op = cmd_op;
        frag_req.addr = cmd_addr;
        frag_req.len = LEN_W'(frag_cnt - 1'b1);
        frag_req.wdata = cmd_wdata;
        // The flag marks the fragment that ends the AFU burst
        frag_req.user = {frag_final, cmd_user};
        frag_req.tag = '0;
    end

    assign mem.req = frag_req;

    always_ff @(posedge axi_afu_if)
    begin
        if (reset_q)
            busy <= 1'b0;
        else if (afu_fire)
            busy <= 1'b1;
        else if (frag_fire && frag_final)
            busy <= 1'b0;
    end

    always_ff @(posedge axi_afu_if)
    begin
        if (afu_fire)
        begin
            cmd_op <= afu_req.op;
            cmd_addr <= afu_req.addr;
            cmd_wdata <= afu_req.wdata;
            cmd_user <= afu_req.user[USER_W-1:0];
            // Writes are single beats regardless of the length field
            if (afu_req.op == lmem_pkg::lmem_op_write)
                cmd_rem <= REM_W'(1);
            else
                cmd_rem <= REM_W'(afu_req.len) + 1'b1;
        end
        else if (frag_fire)
        begin
            cmd_addr <= cmd_addr + ADDR_W'(MAX_BEATS);
            cmd_rem <= cmd_rem - frag_cnt;
        end
    end

    assign frag_issue = frag_fire && (cmd_op == lmem_pkg::lmem_op_read);
    assign frag_beats = frag_cnt[`LMEM_FRAG_CNT_WIDTH-1:0];

    // Responses pass straight through, only last of inner fragments is hidden
    assign afu_rsp_valid = mem.rsp_valid;
    assign mem.rsp_ready = afu_rsp_ready;

    always_comb
    begin
        afu_rsp = mem.rsp;
        afu_rsp.last = mem.rsp.last && mem.rsp.user[USER_W];
        afu_rsp.user[USER_W] = 1'b0;
    end

    // Each read beat taken by the AFU returns one credit
    assign rd_beat_done = mem.rsp_valid && afu_rsp_ready
                          && (mem.rsp.op == lmem_pkg::lmem_op_read);

endmodule

`default_nettype wire

// File: logic/lmem_pkg.sv
// Local memory AXI export types for opcodes, requests and responses

`default_nettype none

`include "lmem_params.svh"

package lmem_pkg;

    // Only reads and writes are carried on the request channel
    typedef enum logic
    {
        lmem_op_read,
        lmem_op_write
    } lmem_op_e;

    // Request on the single combined command and write data channel
    typedef struct packed
    {
        lmem_op_e op;
        logic [`LMEM_ADDR_WIDTH-1:0] addr;
        logic [`LMEM_LEN_WIDTH-1:0] len;
        logic [`LMEM_DATA_WIDTH-1:0] wdata;
        // Top bit is the fragment-last flag added by the burst mapper
        logic [`LMEM_AFU_USER_WIDTH:0] user;
        // Valid only downstream of the user extension stage
        logic [`LMEM_TAG_WIDTH-1:0] tag;
    } lmem_req_t;

    // Response beat for both reads and writes
    typedef struct packed
    {
        lmem_op_e op;
        logic [`LMEM_DATA_WIDTH-1:0] rdata;
        logic last;
        logic [`LMEM_AFU_USER_WIDTH:0] user;
        logic [`LMEM_TAG_WIDTH-1:0] tag;
    } lmem_rsp_t;

endpackage

`default_nettype wire

// File: logic/lmem_reg_pipe.sv
// Chain of valid/ready register slices on the request and response paths

`timescale 1ns/1ps
`default_nettype none

`include "lmem_params.svh"

module lmem_reg_pipe
#(
    // Slices per direction, at least one
    parameter int n_stages = `LMEM_SUGGESTED_REG_STAGES
)
(
    input  logic axi_afu_if,
    input  logic reset_q,
    lmem_axi_if.sink up,
    lmem_axi_if.source down
);

    // Slice registers, index 0 is nearest the producer of each path
    logic req_v [n_stages];
    lmem_pkg::lmem_req_t req_q [n_stages];
    logic rsp_v [n_stages];
    lmem_pkg::lmem_rsp_t rsp_q [n_stages];

    // Inputs into each slice and the ready each slice offers
    logic req_in_v [n_stages];
    lmem_pkg::lmem_req_t req_in [n_stages];
    logic req_rdy [n_stages];
    logic rsp_in_v [n_stages];
    lmem_pkg::lmem_rsp_t rsp_in [n_stages];
    logic rsp_rdy [n_stages];

    always_comb
    begin
        req_in_v[0] = up.req_valid;
        req_in[0] = up.req;
        rsp_in_v[0] = down.rsp_valid;
        rsp_in[0] = down.rsp;
        for (int s = 1; s < n_stages; s++)
        begin
            req_in_v[s] = req_v[s-1];
            req_in[s] = req_q[s-1];
            rsp_in_v[s] = rsp_v[s-1];
            rsp_in[s] = rsp_q[s-1];
        end
    end

    // A slice takes new data when empty or when it is emptying this cycle
    always_comb
    begin
        req_rdy[n_stages-1] = !req_v[n_stages-1] || down.req_ready;
        rsp_rdy[n_stages-1] = !rsp_v[n_stages-1] || up.rsp_ready;
        for (int s = n_stages - 2; s >= 0; s--)
        begin
            req_rdy[s] = !req_v[s] || req_rdy[s+1];
            rsp_rdy[s] = !rsp_v[s] || rsp_rdy[s+1];
        end
    end

    always_ff @(posedge axi_afu_if)
    begin
        for (int s = 0; s < n_stages; s++)
        begin
            if (reset_q)
            begin
                req_v[s] <= 1'b0;
                rsp_v[s] <= 1'b0;
            end
            else
            begin
                if (req_rdy[s])
                    req_v[s] <= req_in_v[s];
                if (rsp_rdy[s])
                    rsp_v[s] <= rsp_in_v[s];
            end
        end
    end

    always_ff @(posedge axi_afu_if)
    begin
        for (int s = 0; s < n_stages; s++)
        begin
            if (req_rdy[s] && req_in_v[s])
                req_q[s] <= req_in[s];
            if (rsp_rdy[s] && rsp_in_v[s])
                rsp_q[s] <= rsp_in[s];
        end
    end

    // Nothing is taken from either neighbour while reset is held
    assign up.req_ready = !reset_q && req_rdy[0];
    assign down.rsp_ready = !reset_q && rsp_rdy[0];

    assign down.req_valid = req_v[n_stages-1];
    assign down.req = req_q[n_stages-1];
    assign up.rsp_valid = rsp_v[n_stages-1];
    assign up.rsp = rsp_q[n_stages-1];

endmodule

`default_nettype wire

// File: logic/lmem_user_ext.sv
// User field extension that parks wide user bits in a tagged table

`timescale 1ns/1ps
`default_nettype none

`include "lmem_params.svh"

module lmem_user_ext
(
    input  logic axi_afu_if,
    input  logic reset_q,
    lmem_axi_if.sink up,
    lmem_axi_if.source down
);

    localparam int TAG_W = `LMEM_TAG_WIDTH;
    localparam int N_TAGS = 1 << `LMEM_TAG_WIDTH;

    // User fields of fragments in flight, indexed by tag
    logic [`LMEM_AFU_USER_WIDTH:0] user_tbl [N_TAGS];
    logic [N_TAGS-1:0] free_map;
    logic [TAG_W-1:0] alloc_tag;
    logic any_free;

    logic req_fire;
    logic rsp_done;
    lmem_pkg::lmem_req_t down_req;
    lmem_pkg::lmem_rsp_t up_rsp;

    // Pick the lowest free entry
    always_comb
    begin
        alloc_tag = '0;
        for (int i = N_TAGS - 1; i >= 0; i--)
        begin
            if (free_map[i])
                alloc_tag = TAG_W'(i);
        end
    end

    assign any_free = |free_map;

    // Requests stall when every tag is taken
    assign down.req_valid = up.req_valid && any_free;
    assign up.req_ready = down.req_ready && any_free;
    assign req_fire = down.req_valid && down.req_ready;

    // The memory does not carry user bits, so only the tag goes down
    always_comb
    begin
        down_req = up.req;
        down_req.user = '0;
        down_req.tag = alloc_tag;
    end

    assign down.req = down_req;

    // Response side restores the user field from the echoed tag
    assign up.rsp_valid = down.rsp_valid;
    assign down.rsp_ready = up.rsp_ready;

    always_comb
    begin
        up_rsp = down.rsp;
        up_rsp.user = user_tbl[down.rsp.tag];
    end

    assign up.rsp = up_rsp;

    // A tag lives until the end of its fragment
    assign rsp_done = down.rsp_valid && down.rsp_ready
                      && (down.rsp.last || (down.rsp.op == lmem_pkg::lmem_op_write));

    always_ff @(posedge axi_afu_if)
    begin
        if (reset_q)
        begin
            free_map <= '1;
        end
        else
        begin
            // Allocated and freed tags never collide in one cycle
            if (req_fire)
                free_map[alloc_tag] <= 1'b0;
            if (rsp_done)
                free_map[down.rsp.tag] <= 1'b1;
        end
    end

    always_ff @(posedge axi_afu_if)
    begin
        if (req_fire)
            user_tbl[alloc_tag] <= up.req.user;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the local memory testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --timing --timescale 1ns/1ps -f compile.f \
    --top-module lmem_as_axi_tb -Mdir obj_dir -o lmem_as_axi_sim \
    && ./obj_dir/lmem_as_axi_sim > "$LOG" 2>&1 \
    || { echo "Build or simulation error"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"
grep -q "^Simulation completed successfully$" "$LOG" && exit 0 || exit 1

// File: verification/lmem_as_axi_checker.sv
// Protocol checker bound to the local memory top level for reset, response hold and credits

`timescale 1ns/1ps
`default_nettype none

`include "lmem_params.svh"

module lmem_as_axi_checker
#(
    // Same headroom as the controller's in-flight counter
    parameter int cnt_w = $clog2(`LMEM_MAX_ACTIVE_RD + `LMEM_FIU_MAX_BEATS + 1)
)
(
    input  logic axi_afu_if,
    input  logic reset,
    input  logic reset_q,
    input  logic req_ready,
    input  logic rsp_valid,
    input  logic rsp_ready,
    input  lmem_pkg::lmem_op_e rsp_op,
    input  logic [`LMEM_DATA_WIDTH-1:0] rsp_rdata,
    input  logic rsp_last,
    input  logic [`LMEM_AFU_USER_WIDTH-1:0] rsp_user,
    input  logic [cnt_w-1:0] rd_active_cnt
);

    // Everything the AFU sees on a response beat
    logic [$bits(lmem_pkg::lmem_op_e) + `LMEM_DATA_WIDTH + `LMEM_AFU_USER_WIDTH:0] rsp_payload;

    assign rsp_payload = {rsp_op, rsp_rdata, rsp_last, rsp_user};

    // A stalled beat stays on the port, unchanged, until the AFU takes it
    rsp_hold: assert property (@(posedge axi_afu_if) disable iff (reset || reset_q)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_payload)))
    else $error("Response beat changed or dropped while rsp_ready was low");

    // The registered reset keeps both AFU-facing handshakes quiet
    reset_quiet: assert property (@(posedge axi_afu_if)
        reset_q |-> (!rsp_valid && !req_ready))
    else $error("rsp_valid or req_ready high while the stages were in reset");

    // Read beats past the gate never exceed the credit limit
    credit_limit: assert property (@(posedge axi_afu_if) disable iff (reset_q)
        int'(rd_active_cnt) <= `LMEM_MAX_ACTIVE_RD)
    else $error("Read beats in flight exceeded the credit limit");

endmodule

// The in-flight counter is taken from the controller inside the top level
bind lmem_as_axi_top lmem_as_axi_checker checker0
(
    .axi_afu_if(axi_afu_if),
    .reset(reset),
    .reset_q(reset_q),
    .req_ready(req_ready),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp_op(rsp_op),
    .rsp_rdata(rsp_rdata),
    .rsp_last(rsp_last),
    .rsp_user(rsp_user),
    .rd_active_cnt(ctrl.rd_active_cnt)
);

`default_nettype wire

// File: verification/lmem_as_axi_tb.sv
// Testbench for the local memory AXI export with a reference memory and a response checker

`timescale 1ns/1ps
`default_nettype none

`include "lmem_params.svh"

module lmem_as_axi_tb;

    localparam int ADDR_W = `LMEM_ADDR_WIDTH;
    localparam int DATA_W = `LMEM_DATA_WIDTH;
    localparam int LEN_W = `LMEM_LEN_WIDTH;
    localparam int USER_W = `LMEM_AFU_USER_WIDTH;
    localparam int MEM_WORDS = 1 << `LMEM_ADDR_WIDTH;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] SEED = 32'h35e4;

    // Burst lengths are beats minus one and some bases wrap past the top
    localparam logic [LEN_W-1:0] BURST_LENS [5] = '{4'd0, 4'd3, 4'd4, 4'd12, 4'd15};
    localparam logic [ADDR_W-1:0] BURST_BASES [5] = '{8'h10, 8'h40, 8'hfe, 8'h80, 8'hf5};

    logic axi_afu_if;
    logic reset;
    logic req_valid;
    logic req_ready;
    lmem_pkg::lmem_op_e req_op;
    logic [ADDR_W-1:0] req_addr;
    logic [LEN_W-1:0] req_len;
    logic [DATA_W-1:0] req_wdata;
    logic [USER_W-1:0] req_user;
    logic rsp_valid;
    logic rsp_ready;
    lmem_pkg::lmem_op_e rsp_op;
    logic [DATA_W-1:0] rsp_rdata;
    logic rsp_last;
    logic [USER_W-1:0] rsp_user;

    // One expected response beat
    typedef struct packed
    {
        logic is_write;
        logic [DATA_W-1:0] data;
        logic last;
        logic [USER_W-1:0] user;
    } exp_beat_t;

    exp_beat_t exp_q [$];
    string exp_test_q [$];
    logic [DATA_W-1:0] ref_mem [MEM_WORDS];
    logic [31:0] data_rng;
    logic [31:0] ready_rng;
    logic stall_enable;
    string test_name;
    int mismatch_count;
    int failure_count;
    int beat_count;

    lmem_as_axi_top dut0
    (
        .axi_afu_if(axi_afu_if),
        .reset(reset),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req_op(req_op),
        .req_addr(req_addr),
        .req_len(req_len),
        .req_wdata(req_wdata),
        .req_user(req_user),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp_op(rsp_op),
        .rsp_rdata(rsp_rdata),
        .rsp_last(rsp_last),
        .rsp_user(rsp_user)
    );

    initial
    begin
        axi_afu_if = 1'b0;
        forever #5 axi_afu_if = ~axi_afu_if;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Word last written at the beat's address, wrapping at the end of memory
    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr,
                                                        input int beat);
        logic [ADDR_W-1:0] a;
        a = addr + ADDR_W'(beat);
        return ref_mem[a];
    endfunction

    task automatic report_mismatch(input string test, input string field,
                                   input logic [DATA_W-1:0] expected,
                                   input logic [DATA_W-1:0] actual);
        mismatch_count++;
        $display("[ERROR] %s %s: expected %h, actual %h", test, field, expected, actual);
    endtask

    // Drive one request and queue the beats it should return once it is accepted
    task automatic send_req(input logic is_write, input logic [ADDR_W-1:0] addr,
                            input logic [LEN_W-1:0] len, input logic [DATA_W-1:0] wdata,
                            input logic [USER_W-1:0] user);
        int waited;
        exp_beat_t beat;
        @(negedge axi_afu_if);
        req_valid = 1'b1;
        req_op = is_write ? lmem_pkg::lmem_op_write : lmem_pkg::lmem_op_read;
        req_addr = addr;
        req_len = len;
        req_wdata = wdata;
        req_user = user;
        waited = 0;
        // req_ready is registered state only, so it holds through the next rising edge
        while (req_ready !== 1'b1 && waited < TIMEOUT_CYCLES)
        begin
            @(negedge axi_afu_if);
            waited++;
        end
        if (req_ready !== 1'b1)
        begin
            failure_count++;
            $display("Request in test %s was not accepted within %0d cycles",
                     test_name, TIMEOUT_CYCLES);
        end
        else if (is_write)
        begin
            ref_mem[addr] = wdata;
            beat.is_write = 1'b1;
            beat.data = '0;
            beat.last = 1'b1;
            beat.user = user;
            exp_q.push_back(beat);
            exp_test_q.push_back(test_name);
        end
        else
        begin
            for (int b = 0; b <= int'(len); b++)
            begin
                beat.is_write = 1'b0;
                beat.data = expected_read(addr, b);
                beat.last = (b == int'(len));
                beat.user = user;
                exp_q.push_back(beat);
                exp_test_q.push_back(test_name);
            end
        end
        @(negedge axi_afu_if);
        req_valid = 1'b0;
    endtask

    // Wait until every queued beat has come back
    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES)
        begin
            @(negedge axi_afu_if);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            failure_count++;
            $display("Test %s still missed %0d response beats after %0d cycles",
                     test_name, exp_q.size(), TIMEOUT_CYCLES);
            exp_q.delete();
            exp_test_q.delete();
        end
    endtask

    // The compare process also owns rsp_ready
    initial
    begin : compare_responses
        exp_beat_t want;
        string name;
        rsp_ready = 1'b0;
        ready_rng = xorshift32(SEED);
        forever
        begin
            @(negedge axi_afu_if);
            ready_rng = xorshift32(ready_rng);
            // Withholds ready on about three cycles in eight while stalls are on
            rsp_ready = !stall_enable || (ready_rng[2:0] > 3'd2);
            // Response outputs are registered, so this beat transfers on the next rising edge
            if (!reset && rsp_valid && rsp_ready)
            begin
                if (exp_q.size() == 0)
                begin
                    failure_count++;
                    $display("A response beat arrived with no request outstanding, data %h",
                             rsp_rdata);
                end
                else
                begin
                    want = exp_q.pop_front();
                    name = exp_test_q.pop_front();
                    beat_count++;
                    if ((rsp_op == lmem_pkg::lmem_op_write) !== want.is_write)
                        report_mismatch(name, "op is write", DATA_W'(want.is_write),
                                        DATA_W'(rsp_op == lmem_pkg::lmem_op_write));
                    if (!want.is_write && rsp_rdata !== want.data)
                        report_mismatch(name, "rdata", want.data, rsp_rdata);
                    if (rsp_last !== want.last)
                        report_mismatch(name, "last", DATA_W'(want.last), DATA_W'(rsp_last));
                    if (rsp_user !== want.user)
                        report_mismatch(name, "user", DATA_W'(want.user), DATA_W'(rsp_user));
                end
            end
        end
    end

    initial
    begin : main_sequence
        int waited;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        reset = 1'b1;
        req_valid = 1'b0;
        req_op = lmem_pkg::lmem_op_read;
        req_addr = '0;
        req_len = '0;
        req_wdata = '0;
        req_user = '0;
        stall_enable = 1'b0;
        mismatch_count = 0;
        failure_count = 0;
        beat_count = 0;
        data_rng = SEED;
        test_name = "reset";

        // The first cycle is skipped since the registered reset has not reached the stages
        // The last falling edge samples the cycle after reset, which is checked below
        for (int c = 0; c < 5; c++)
        begin
            @(negedge axi_afu_if);
            if (c >= 1 && c < 4 && (rsp_valid !== 1'b0 || req_ready !== 1'b0))
            begin
                failure_count++;
                $display("rsp_valid or req_ready was high in reset cycle %0d", c);
            end
        end
        reset = 1'b0;
        // The stages still see reset for one more cycle
        if (rsp_valid !== 1'b0 || req_ready !== 1'b0)
        begin
            failure_count++;
            $display("rsp_valid or req_ready was high in the cycle after reset");
        end
        waited = 0;
        while (req_ready !== 1'b1 && waited < TIMEOUT_CYCLES)
        begin
            @(negedge axi_afu_if);
            waited++;
        end
        if (req_ready !== 1'b1)
        begin
            failure_count++;
            $display("req_ready did not rise within %0d cycles after reset", TIMEOUT_CYCLES);
        end
        send_req(1'b1, 8'h42, '0, 32'h0bad_cafe, 8'h3c);
        send_req(1'b0, 8'h42, '0, '0, 8'hc3);
        wait_idle();

        // Fill the whole memory so bursts compare against known words
        test_name = "fill";
        for (int a = 0; a < MEM_WORDS; a++)
        begin
            data_rng = xorshift32(data_rng);
            addr = ADDR_W'(a);
            wdata = {addr, ~addr, data_rng[15:0]};
            send_req(1'b1, addr, '0, wdata, data_rng[23:16]);
        end
        wait_idle();

        test_name = "single_write_read";
        for (int i = 0; i < 32; i++)
        begin
            data_rng = xorshift32(data_rng);
            send_req(1'b1, ADDR_W'(i * 37 + 5), '0, data_rng, data_rng[31:24]);
        end
        for (int i = 0; i < 32; i++)
        begin
            data_rng = xorshift32(data_rng);
            send_req(1'b0, ADDR_W'(i * 37 + 5), '0, '0, data_rng[7:0]);
        end
        wait_idle();

        // Longer bursts are split into 4-beat fragments inside the design
        test_name = "read_bursts";
        for (int i = 0; i < 5; i++)
            send_req(1'b0, BURST_BASES[i], BURST_LENS[i], '0, USER_W'(8'h90 + i));
        wait_idle();

        test_name = "user_passthrough";
        for (int i = 0; i < 4; i++)
        begin
            data_rng = xorshift32(data_rng);
            wdata = data_rng;
            addr = ADDR_W'(8'hc0 + i);
            send_req(1'b1, addr, '0, wdata, USER_W'(8'h5a * i + 8'h0f * (i & 1)));
            send_req(1'b0, addr, 4'd5, '0, ~USER_W'(8'h5a * i));
        end
        wait_idle();

        // Random back-pressure with mostly read bursts issued back to back
        test_name = "backpressure";
        stall_enable = 1'b1;
        for (int i = 0; i < 24; i++)
        begin
            data_rng = xorshift32(data_rng);
            wdata = xorshift32(data_rng);
            send_req(data_rng[2:0] == 3'd0, data_rng[15:8], data_rng[19:16], wdata,
                     data_rng[27:20]);
        end
        wait_idle();
        stall_enable = 1'b0;

        // Stray beats after the last expected one would show up here
        repeat (20) @(negedge axi_afu_if);

        $display("Checks done: %0d beats compared, %0d mismatches, %0d other failures",
                 beat_count, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
